// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= load_issue_queue_tb
FILELIST  ?= compile.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
rtl/lsq_pkg.sv
rtl/age_matrix_selector.sv
rtl/load_issue_bank.sv
rtl/load_issue_queue.sv
sim/tb_clock_gen.sv
sim/load_issue_queue_tb.sv

// File: rtl/age_matrix_selector.sv
`timescale 1ns/1ps

module age_matrix_selector (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [lsq_pkg::BANK_SIZE-1:0] alloc_i,
    input  logic [lsq_pkg::BANK_SIZE-1:0] req_i,
    output logic [lsq_pkg::BANK_SIZE-1:0] grant_o
);

    import lsq_pkg::*;

    // older_q[i][j] is set when entry i was allocated before entry j.
    logic [BANK_SIZE-1:0][BANK_SIZE-1:0] older_q;
    logic [BANK_SIZE-1:0]                blocked;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            older_q <= '0;
        end else begin
            for (int i = 0; i < BANK_SIZE; i++) begin
                for (int j = 0; j < BANK_SIZE; j++) begin
                    if (i != j) begin
                        // A new entry is younger than everything already held.
                        if (alloc_i[i]) begin
                            older_q[i][j] <= 1'b0;
                        end else if (alloc_i[j]) begin
                            older_q[i][j] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // An entry is blocked when some other requester is older than it.
    always_comb begin
        blocked = '0;
        for (int i = 0; i < BANK_SIZE; i++) begin
            for (int j = 0; j < BANK_SIZE; j++) begin
                if (req_i[j] && older_q[j][i]) begin
                    blocked[i] = 1'b1;
                end
            end
        end
    end

    assign grant_o = req_i & ~blocked;

    grant_onehot_a: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(grant_o));

    // The order must stay total over the live entries, so a request always wins.
    grant_live_a: assert property (@(posedge clk) disable iff (!rst)
        (req_i != '0) |-> (grant_o != '0));

endmodule

// File: rtl/load_issue_bank.sv
`timescale 1ns/1ps

module load_issue_bank (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             dis_valid_i,
    input  logic [lsq_pkg::PREG_W-1:0]                       dis_rs1_i,
    input  logic                                             dis_rs1_ready_i,
    input  lsq_pkg::load_payload_t                           dis_payload_i,
    output logic                                             full_o,
    input  logic [lsq_pkg::WAKEUP_NUM-1:0]                   wakeup_valid_i,
    input  logic [lsq_pkg::WAKEUP_NUM-1:0][lsq_pkg::PREG_W-1:0] wakeup_preg_i,
    output logic                                             reg_read_en_o,
    output logic [lsq_pkg::PREG_W-1:0]                       reg_read_preg_o,
    output logic                                             issue_valid_o,
    output logic [lsq_pkg::ENTRY_W-1:0]                      issue_entry_o,
    output lsq_pkg::load_payload_t                           issue_payload_o,
    input  logic                                             reply_valid_i,
    input  logic [lsq_pkg::ENTRY_W-1:0]                      reply_entry_i,
    input  logic                                             success_valid_i,
    input  logic [lsq_pkg::ENTRY_W-1:0]                      success_entry_i,
    input  logic                                             redirect_i,
    input  lsq_pkg::rob_idx_t                                redirect_rob_idx_i
);

    import lsq_pkg::*;

    entry_state_e  [BANK_SIZE-1:0]             state_q;
    logic          [BANK_SIZE-1:0]             rs1_ready_q;
    logic          [BANK_SIZE-1:0][PREG_W-1:0] rs1_q;
    load_payload_t [BANK_SIZE-1:0]             payload_q;

    logic [BANK_SIZE-1:0] free_vec;
    logic [BANK_SIZE-1:0] alloc_vec;
    logic [BANK_SIZE-1:0] wake_hit;
    logic [BANK_SIZE-1:0] req;
    logic [BANK_SIZE-1:0] grant;
    logic [BANK_SIZE-1:0] flush;
    logic [BANK_SIZE-1:0] success_hit;
    logic [BANK_SIZE-1:0] reply_hit;
    logic [ENTRY_W-1:0]   free_idx;
    logic [ENTRY_W-1:0]   sel_idx;
    logic                 alloc_en;
    logic                 dis_wake;

    always_comb begin
        for (int i = 0; i < BANK_SIZE; i++) begin
            free_vec[i]    = state_q[i] == ST_FREE;
            req[i]         = (state_q[i] == ST_WAIT) && rs1_ready_q[i] && !redirect_i;
            flush[i]       = redirect_i && (state_q[i] != ST_FREE) &&
                             rob_is_younger(payload_q[i].rob_idx, redirect_rob_idx_i);
            success_hit[i] = success_valid_i && (success_entry_i == ENTRY_W'(i));
            reply_hit[i]   = reply_valid_i && (reply_entry_i == ENTRY_W'(i));
        end
    end

    assign full_o   = ~|free_vec;
    // Dispatches during a redirect belong to the wrong path.
    assign alloc_en = dis_valid_i && !full_o && !redirect_i;

    // Lowest free entry takes the new load.
    always_comb begin
        alloc_vec = '0;
        free_idx  = '0;
        for (int i = BANK_SIZE - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                free_idx = ENTRY_W'(i);
            end
        end
        alloc_vec[free_idx] = alloc_en;
    end

    always_comb begin
        wake_hit = '0;
        dis_wake = 1'b0;
        for (int w = 0; w < WAKEUP_NUM; w++) begin
            if (wakeup_valid_i[w] && (wakeup_preg_i[w] == dis_rs1_i)) begin
                dis_wake = 1'b1;
            end
            for (int i = 0; i < BANK_SIZE; i++) begin
                if (wakeup_valid_i[w] && (wakeup_preg_i[w] == rs1_q[i])) begin
                    wake_hit[i] = 1'b1;
                end
            end
        end
    end

    age_matrix_selector age_matrix_selector_inst (
        .clk     (clk),
        .rst     (rst),
        .alloc_i (alloc_vec),
        .req_i   (req),
        .grant_o (grant)
    );

    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < BANK_SIZE; i++) begin
            if (grant[i]) begin
                sel_idx = ENTRY_W'(i);
            end
        end
    end

    assign reg_read_en_o   = |grant;
    assign reg_read_preg_o = rs1_q[sel_idx];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < BANK_SIZE; i++) begin
                state_q[i] <= ST_FREE;
            end
            rs1_ready_q   <= '0;
            issue_valid_o <= 1'b0;
        end else begin
            for (int i = 0; i < BANK_SIZE; i++) begin
                if (flush[i] || success_hit[i]) begin
                    state_q[i] <= ST_FREE;
                end else if (reply_hit[i]) begin
                    state_q[i] <= ST_WAIT;
                end else if (grant[i]) begin
                    state_q[i] <= ST_ISSUED;
                end else if (alloc_vec[i]) begin
                    state_q[i] <= ST_WAIT;
                end

                // A replayed entry keeps its ready bit.
                if (alloc_vec[i]) begin
                    rs1_ready_q[i] <= dis_rs1_ready_i | dis_wake;
                end else if ((state_q[i] == ST_WAIT) && wake_hit[i]) begin
                    rs1_ready_q[i] <= 1'b1;
                end
            end
            issue_valid_o <= |grant;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            rs1_q[free_idx]     <= dis_rs1_i;
            payload_q[free_idx] <= dis_payload_i;
        end
        issue_entry_o   <= sel_idx;
        issue_payload_o <= payload_q[sel_idx];
    end

    no_dis_when_full_a: assert property (@(posedge clk) disable iff (!rst)
        dis_valid_i |-> !full_o);

endmodule

// File: rtl/load_issue_queue.sv
`timescale 1ns/1ps

module load_issue_queue (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic [lsq_pkg::BANK_NUM-1:0]                      dis_valid_i,
    input  logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::PREG_W-1:0] dis_rs1_i,
    input  logic [lsq_pkg::BANK_NUM-1:0]                      dis_rs1_ready_i,
    input  logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::PREG_W-1:0] dis_rd_i,
    input  logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::IMM_W-1:0]  dis_imm_i,
    input  lsq_pkg::mem_size_e [lsq_pkg::BANK_NUM-1:0]        dis_size_i,
    input  logic [lsq_pkg::BANK_NUM-1:0]                      dis_uext_i,
    input  logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::LQ_W-1:0]   dis_lq_idx_i,
    input  lsq_pkg::rob_idx_t [lsq_pkg::BANK_NUM-1:0]         dis_rob_idx_i,
    output logic                                              dis_full_o,
    input  logic [lsq_pkg::WAKEUP_NUM-1:0]                    wakeup_valid_i,
    input  logic [lsq_pkg::WAKEUP_NUM-1:0][lsq_pkg::PREG_W-1:0] wakeup_preg_i,
    output logic [lsq_pkg::BANK_NUM-1:0]                      reg_read_en_o,
    output logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::PREG_W-1:0] reg_read_preg_o,
    output logic [lsq_pkg::BANK_NUM-1:0]                      issue_valid_o,
    output logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::ENTRY_W-1:0] issue_entry_o,
    output logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::PREG_W-1:0] issue_rd_o,
    output logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::IMM_W-1:0]  issue_imm_o,
    output lsq_pkg::mem_size_e [lsq_pkg::BANK_NUM-1:0]        issue_size_o,
    output logic [lsq_pkg::BANK_NUM-1:0]                      issue_uext_o,
    output logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::LQ_W-1:0]   issue_lq_idx_o,
    output lsq_pkg::rob_idx_t [lsq_pkg::BANK_NUM-1:0]         issue_rob_idx_o,
    input  logic [lsq_pkg::BANK_NUM-1:0]                      reply_valid_i,
    input  logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::ENTRY_W-1:0] reply_entry_i,
    input  logic [lsq_pkg::BANK_NUM-1:0]                      success_valid_i,
    input  logic [lsq_pkg::BANK_NUM-1:0][lsq_pkg::ENTRY_W-1:0] success_entry_i,
    input  logic                                              redirect_i,
    input  lsq_pkg::rob_idx_t                                 redirect_rob_idx_i
);

    import lsq_pkg::*;

    load_payload_t [BANK_NUM-1:0] slot_payload;
    load_payload_t [BANK_NUM-1:0] issue_payload;
    logic          [BANK_NUM-1:0] bank_full;

    assign dis_full_o = |bank_full;

    for (genvar s = 0; s < BANK_NUM; s++) begin : g_slot
        assign slot_payload[s] = '{
            rd:      dis_rd_i[s],
            imm:     dis_imm_i[s],
            size:    dis_size_i[s],
            uext:    dis_uext_i[s],
            lq_idx:  dis_lq_idx_i[s],
            rob_idx: dis_rob_idx_i[s]
        };
    end

    for (genvar k = 0; k < BANK_NUM; k++) begin : g_bank
        logic take_slot0;
        logic take_slot1;
        logic slot;
        logic bank_valid;

        // Two slots in one cycle carry consecutive lq indices, so at most one matches.
        assign take_slot0 = dis_valid_i[0] && (dis_lq_idx_i[0][0] == 1'(k));
        assign take_slot1 = dis_valid_i[1] && (dis_lq_idx_i[1][0] == 1'(k));
        assign slot       = !take_slot0;
        assign bank_valid = (take_slot0 || take_slot1) && !dis_full_o;

        load_issue_bank load_issue_bank_inst (
            .clk                (clk),
            .rst                (rst),
            .dis_valid_i        (bank_valid),
            .dis_rs1_i          (dis_rs1_i[slot]),
            .dis_rs1_ready_i    (dis_rs1_ready_i[slot]),
            .dis_payload_i      (slot_payload[slot]),
            .full_o             (bank_full[k]),
            .wakeup_valid_i     (wakeup_valid_i),
            .wakeup_preg_i      (wakeup_preg_i),
            .reg_read_en_o      (reg_read_en_o[k]),
            .reg_read_preg_o    (reg_read_preg_o[k]),
            .issue_valid_o      (issue_valid_o[k]),
            .issue_entry_o      (issue_entry_o[k]),
            .issue_payload_o    (issue_payload[k]),
            .reply_valid_i      (reply_valid_i[k]),
            .reply_entry_i      (reply_entry_i[k]),
            .success_valid_i    (success_valid_i[k]),
            .success_entry_i    (success_entry_i[k]),
            .redirect_i         (redirect_i),
            .redirect_rob_idx_i (redirect_rob_idx_i)
        );

        assign issue_rd_o[k]      = issue_payload[k].rd;
        assign issue_imm_o[k]     = issue_payload[k].imm;
        assign issue_size_o[k]    = issue_payload[k].size;
        assign issue_uext_o[k]    = issue_payload[k].uext;
        assign issue_lq_idx_o[k]  = issue_payload[k].lq_idx;
        assign issue_rob_idx_o[k] = issue_payload[k].rob_idx;
    end

endmodule

// File: rtl/lsq_pkg.sv
package lsq_pkg;

    localparam int BANK_NUM   = 2;
    localparam int BANK_SIZE  = 8;
    localparam int ENTRY_W    = 3;
    localparam int PREG_W     = 6;
    localparam int ROB_W      = 5;
    localparam int LQ_W       = 4;
    localparam int IMM_W      = 12;
    localparam int WAKEUP_NUM = 2;

    // The direction bit flips each time the ROB index wraps around.
    typedef struct packed {
        logic             dir;
        logic [ROB_W-1:0] idx;
    } rob_idx_t;

    typedef enum logic [1:0] {
        ST_FREE   = 2'd0,
        ST_WAIT   = 2'd1,
        ST_ISSUED = 2'd2
    } entry_state_e;

    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_HALF  = 2'd1,
        SZ_WORD  = 2'd2,
        SZ_DWORD = 2'd3
    } mem_size_e;

    typedef struct packed {
        logic [PREG_W-1:0] rd;
        logic [IMM_W-1:0]  imm;
        mem_size_e         size;
        logic              uext;
        logic [LQ_W-1:0]   lq_idx;
        rob_idx_t          rob_idx;
    } load_payload_t;

    // True when a is strictly younger than b.
    // With different direction bits the younger one has already wrapped,
    // so its raw index is the smaller one.
    function automatic logic rob_is_younger(input rob_idx_t a, input rob_idx_t b);
        logic younger;
        if (a.dir == b.dir) begin
            younger = a.idx > b.idx;
        end else begin
            younger = a.idx < b.idx;
        end
        return younger;
    endfunction

endpackage

// File: sim/load_issue_queue_tb.sv
`timescale 1ns/1ps

module load_issue_queue_tb;

    import lsq_pkg::*;

    localparam logic [31:0] SEED          = 32'h64a8_0cb1;
    localparam int          BUDGET_CYCLES = 10 + 20 + 30 + 30 + 60 + 40;
    localparam int          MARGIN_CYCLES = 100;
    localparam int          TIMEOUT_NS    = (BUDGET_CYCLES + MARGIN_CYCLES) * 20;

    typedef struct packed {
        logic [31:0]        cyc;
        logic [ENTRY_W-1:0] entry;
        load_payload_t      payload;
    } issue_rec_t;

    logic clk;
    logic rst;
    logic [1:0]                       dis_valid;
    logic [1:0][PREG_W-1:0]           dis_rs1;
    logic [1:0]                       dis_rs1_ready;
    logic [1:0][PREG_W-1:0]           dis_rd;
    logic [1:0][IMM_W-1:0]            dis_imm;
    mem_size_e [1:0]                  dis_size;
    logic [1:0]                       dis_uext;
    logic [1:0][LQ_W-1:0]             dis_lq_idx;
    rob_idx_t [1:0]                   dis_rob_idx;
    logic                             dis_full;
    logic [WAKEUP_NUM-1:0]            wakeup_valid;
    logic [WAKEUP_NUM-1:0][PREG_W-1:0] wakeup_preg;
    logic [1:0]                       reg_read_en;
    logic [1:0][PREG_W-1:0]           reg_read_preg;
    logic [1:0]                       issue_valid;
    logic [1:0][ENTRY_W-1:0]          issue_entry;
    logic [1:0][PREG_W-1:0]           issue_rd;
    logic [1:0][IMM_W-1:0]            issue_imm;
    mem_size_e [1:0]                  issue_size;
    logic [1:0]                       issue_uext;
    logic [1:0][LQ_W-1:0]             issue_lq_idx;
    rob_idx_t [1:0]                   issue_rob_idx;
    logic [1:0]                       reply_valid;
    logic [1:0][ENTRY_W-1:0]          reply_entry;
    logic [1:0]                       success_valid;
    logic [1:0][ENTRY_W-1:0]          success_entry;
    logic                             redirect;
    rob_idx_t                         redirect_rob_idx;

    logic [31:0] cyc;
    issue_rec_t  iss_q[2][$];
    int          errors;
    int          tests_failed;

    tb_clock_gen tb_clock_gen_inst (.clk_o(clk), .rst_o(rst));

    load_issue_queue load_issue_queue_inst (
        .clk(clk), .rst(rst),
        .dis_valid_i(dis_valid), .dis_rs1_i(dis_rs1), .dis_rs1_ready_i(dis_rs1_ready),
        .dis_rd_i(dis_rd), .dis_imm_i(dis_imm), .dis_size_i(dis_size),
        .dis_uext_i(dis_uext), .dis_lq_idx_i(dis_lq_idx), .dis_rob_idx_i(dis_rob_idx),
        .dis_full_o(dis_full),
        .wakeup_valid_i(wakeup_valid), .wakeup_preg_i(wakeup_preg),
        .reg_read_en_o(reg_read_en), .reg_read_preg_o(reg_read_preg),
        .issue_valid_o(issue_valid), .issue_entry_o(issue_entry),
        .issue_rd_o(issue_rd), .issue_imm_o(issue_imm), .issue_size_o(issue_size),
        .issue_uext_o(issue_uext), .issue_lq_idx_o(issue_lq_idx),
        .issue_rob_idx_o(issue_rob_idx),
        .reply_valid_i(reply_valid), .reply_entry_i(reply_entry),
        .success_valid_i(success_valid), .success_entry_i(success_entry),
        .redirect_i(redirect), .redirect_rob_idx_i(redirect_rob_idx)
    );

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 32'd1;
        end
    end

    // Issues are recorded mid-cycle, when the registered outputs are settled.
    always @(negedge clk) begin
        issue_rec_t rec;
        if (rst) begin
            for (int p = 0; p < 2; p++) begin
                if (issue_valid[p]) begin
                    rec.cyc             = cyc;
                    rec.entry           = issue_entry[p];
                    rec.payload.rd      = issue_rd[p];
                    rec.payload.imm     = issue_imm[p];
                    rec.payload.size    = issue_size[p];
                    rec.payload.uext    = issue_uext[p];
                    rec.payload.lq_idx  = issue_lq_idx[p];
                    rec.payload.rob_idx = issue_rob_idx[p];
                    iss_q[p].push_back(rec);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the run did not complete.", TIMEOUT_NS);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        dis_valid        = '0;
        dis_rs1          = '0;
        dis_rs1_ready    = '0;
        dis_rd           = '0;
        dis_imm          = '0;
        dis_size         = {SZ_BYTE, SZ_BYTE};
        dis_uext         = '0;
        dis_lq_idx       = '0;
        dis_rob_idx      = '0;
        wakeup_valid     = '0;
        wakeup_preg      = '0;
        reply_valid      = '0;
        reply_entry      = '0;
        success_valid    = '0;
        success_entry    = '0;
        redirect         = 1'b0;
        redirect_rob_idx = '0;
    endtask

    task automatic compare_val(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    function automatic load_payload_t make_load(input int lq, input logic [5:0] rob);
        load_payload_t p;
        p.rd      = PREG_W'($urandom);
        p.imm     = IMM_W'($urandom);
        p.size    = mem_size_e'(2'($urandom));
        p.uext    = 1'($urandom);
        p.lq_idx  = LQ_W'(lq);
        p.rob_idx = rob_idx_t'(rob);
        return p;
    endfunction

    task automatic set_slot(input int s, input logic [PREG_W-1:0] rs1, input logic rdy,
                            input load_payload_t p);
        dis_valid[s]     = 1'b1;
        dis_rs1[s]       = rs1;
        dis_rs1_ready[s] = rdy;
        dis_rd[s]        = p.rd;
        dis_imm[s]       = p.imm;
        dis_size[s]      = p.size;
        dis_uext[s]      = p.uext;
        dis_lq_idx[s]    = p.lq_idx;
        dis_rob_idx[s]   = p.rob_idx;
    endtask

    // Returns the cycle count that the accepting edge produces.
    task automatic finish_dispatch(input string name, output logic [31:0] acc);
        if (dis_full) begin
            $display("%s: dispatch attempted while the queue reported full.", name);
            errors++;
        end
        acc = cyc + 32'd1;
        step();
        dis_valid = '0;
    endtask

    task automatic wait_issue(input string name, input int port, input int limit,
                              output issue_rec_t rec, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (iss_q[port].size() == 0 && n < limit) begin
            step();
            n++;
        end
        if (iss_q[port].size() != 0) begin
            rec = iss_q[port].pop_front();
            ok  = 1'b1;
        end else begin
            $display("%s: port %0d issued nothing within %0d cycles.", name, port, limit);
            errors++;
        end
    endtask

    task automatic check_issue(input string name, input issue_rec_t rec,
                               input load_payload_t exp);
        compare_val({name, " payload"}, 64'(exp), 64'(rec.payload));
    endtask

    // Frees every entry younger than rob, then drops the recorded history.
    task automatic flush_all(input logic [5:0] rob);
        redirect         = 1'b1;
        redirect_rob_idx = rob_idx_t'(rob);
        step();
        redirect = 1'b0;
        step();
        step();
        iss_q[0].delete();
        iss_q[1].delete();
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    task automatic test_ready_dispatch();
        load_payload_t     p;
        logic [PREG_W-1:0] rs1;
        logic [31:0]       acc;
        issue_rec_t        rec;
        bit                ok;
        int                e0;
        e0  = errors;
        rs1 = PREG_W'($urandom);
        p   = make_load(0, 6'd1);
        set_slot(0, rs1, 1'b1, p);
        finish_dispatch("ready_dispatch", acc);
        compare_val("ready_dispatch reg_read_en", 64'(1), 64'(reg_read_en[0]));
        compare_val("ready_dispatch reg_read_preg", 64'(rs1), 64'(reg_read_preg[0]));
        wait_issue("ready_dispatch", 0, 10, rec, ok);
        if (ok) begin
            compare_val("ready_dispatch issue cycle", 64'(acc + 32'd1), 64'(rec.cyc));
            check_issue("ready_dispatch", rec, p);
        end
        flush_all(6'd0);
        report_test("ready_dispatch", e0);
    endtask

    task automatic test_wakeup();
        load_payload_t     p;
        logic [PREG_W-1:0] rs1;
        logic [31:0]       acc;
        logic [31:0]       wake_cyc;
        issue_rec_t        rec;
        bit                ok;
        int                e0;
        e0  = errors;
        rs1 = PREG_W'($urandom);
        p   = make_load(0, 6'd1);
        set_slot(0, rs1, 1'b0, p);
        finish_dispatch("wakeup", acc);
        wakeup_valid[1] = 1'b1;
        wakeup_preg[1]  = rs1 ^ PREG_W'(1);
        step();
        wakeup_valid = '0;
        repeat (4) step();
        compare_val("wakeup early issues", 64'(0), 64'(iss_q[0].size()));
        wakeup_valid[0] = 1'b1;
        wakeup_preg[0]  = rs1;
        wake_cyc        = cyc;
        step();
        wakeup_valid = '0;
        wait_issue("wakeup", 0, 10, rec, ok);
        if (ok) begin
            compare_val("wakeup issue cycle", 64'(wake_cyc + 32'd2), 64'(rec.cyc));
            check_issue("wakeup", rec, p);
        end
        flush_all(6'd0);
        report_test("wakeup", e0);
    endtask

    task automatic test_steer_age();
        load_payload_t     p[4];
        logic [PREG_W-1:0] rs1[4];
        logic [PREG_W-1:0] base;
        logic [31:0]       acc;
        issue_rec_t        rec;
        bit                ok;
        int                e0;
        e0   = errors;
        base = PREG_W'($urandom);
        for (int i = 0; i < 4; i++) begin
            rs1[i] = base + PREG_W'(i);
            p[i]   = make_load(i, 6'(i + 1));
        end
        // Ready fillers hold entry 0 of each bank until their success.
        // The younger pair then reuses entry 0, so age order differs from entry order.
        set_slot(0, base + PREG_W'(4), 1'b1, make_load(14, 6'd0));
        set_slot(1, base + PREG_W'(5), 1'b1, make_load(15, 6'd0));
        finish_dispatch("steer_age", acc);
        set_slot(0, rs1[0], 1'b0, p[0]);
        set_slot(1, rs1[1], 1'b0, p[1]);
        finish_dispatch("steer_age", acc);
        for (int k = 0; k < 2; k++) begin
            wait_issue("steer_age", k, 10, rec, ok);
            success_valid[k] = ok;
            success_entry[k] = rec.entry;
        end
        step();
        success_valid = '0;
        set_slot(0, rs1[2], 1'b0, p[2]);
        set_slot(1, rs1[3], 1'b0, p[3]);
        finish_dispatch("steer_age", acc);
        // A redirect at the youngest index flushes nothing but holds off selection,
        // so the younger loads wake first and all four are ready together.
        redirect         = 1'b1;
        redirect_rob_idx = rob_idx_t'(6'd4);
        wakeup_valid     = 2'b11;
        wakeup_preg      = {rs1[3], rs1[2]};
        step();
        wakeup_preg = {rs1[1], rs1[0]};
        step();
        redirect     = 1'b0;
        wakeup_valid = '0;
        for (int k = 0; k < 4; k++) begin
            wait_issue("steer_age", k % 2, 10, rec, ok);
            if (ok) begin
                check_issue("steer_age", rec, p[k]);
            end
        end
        flush_all(6'd0);
        report_test("steer_age", e0);
    endtask

    task automatic test_reply_success();
        load_payload_t p;
        logic [31:0]   acc;
        issue_rec_t    rec;
        issue_rec_t    rec2;
        bit            ok;
        int            e0;
        e0 = errors;
        p  = make_load(0, 6'd1);
        set_slot(0, PREG_W'($urandom), 1'b1, p);
        finish_dispatch("reply_success", acc);
        wait_issue("reply_success", 0, 10, rec, ok);
        if (ok) begin
            reply_valid[0] = 1'b1;
            reply_entry[0] = rec.entry;
            step();
            reply_valid = '0;
            wait_issue("reply_success", 0, 10, rec2, ok);
            if (ok) begin
                compare_val("reply_success replay entry", 64'(rec.entry), 64'(rec2.entry));
                check_issue("reply_success replay", rec2, p);
                success_valid[0] = 1'b1;
                success_entry[0] = rec2.entry;
                step();
                success_valid = '0;
                repeat (6) step();
                compare_val("reply_success issues after success", 64'(0),
                            64'(iss_q[0].size()));
            end
        end
        // Only the last load is ready, so it issues and later takes the success.
        for (int i = 0; i < BANK_SIZE; i++) begin
            set_slot(0, PREG_W'($urandom), i == BANK_SIZE - 1,
                     make_load(2 * i, 6'(i + 2)));
            finish_dispatch("reply_success", acc);
        end
        compare_val("reply_success full", 64'(1), 64'(dis_full));
        wait_issue("reply_success", 0, 10, rec, ok);
        success_valid[0] = ok;
        success_entry[0] = rec.entry;
        step();
        success_valid = '0;
        compare_val("reply_success full after free", 64'(0), 64'(dis_full));
        flush_all(6'd0);
        report_test("reply_success", e0);
    endtask

    task automatic test_redirect();
        logic [PREG_W-1:0] rs1[6];
        logic [PREG_W-1:0] base;
        logic [31:0]       acc;
        issue_rec_t        rec;
        int                seen;
        int                e0;
        e0   = errors;
        base = PREG_W'($urandom);
        // Indices 0x1D to 0x22 cross the point where the direction bit flips.
        for (int i = 0; i < 6; i++) begin
            rs1[i] = base + PREG_W'(i);
            set_slot(0, rs1[i], 1'b0, make_load(i, 6'(32'h1d + i)));
            finish_dispatch("redirect", acc);
        end
        redirect         = 1'b1;
        redirect_rob_idx = rob_idx_t'(6'h1f);
        step();
        redirect = 1'b0;
        for (int i = 0; i < 6; i += 2) begin
            wakeup_valid = 2'b11;
            wakeup_preg  = {rs1[i + 1], rs1[i]};
            step();
        end
        wakeup_valid = '0;
        repeat (10) step();
        seen = 0;
        for (int p = 0; p < 2; p++) begin
            while (iss_q[p].size() != 0) begin
                rec = iss_q[p].pop_front();
                seen++;
                if (rec.payload.lq_idx > LQ_W'(2)) begin
                    $display("** Error redirect: expected lq_idx <= 2, actual %0h",
                             rec.payload.lq_idx);
                    errors++;
                end
            end
        end
        compare_val("redirect issue count", 64'(3), 64'(seen));
        flush_all(6'h1c);
        report_test("redirect", e0);
    endtask

    initial begin
        idle_inputs();
        errors       = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        @(posedge rst);
        step();
        test_ready_dispatch();
        test_wakeup();
        test_steer_age();
        test_reply_success();
        test_redirect();
        $display("Tests run: 5, tests failed: %0d, errors: %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 10;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Reset is released shortly after an edge so that it never races the clock.
    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b1;
    end

endmodule
